// ==== sources.f ====
src/obj_pkg.sv
src/video_pkg.sv
src/obj_line_scan.sv
src/obj_pri_queue.sv
src/obj_tile_draw.sv
src/obj_line_buf.sv
src/raizing_obj.sv
tests/raizing_obj_asserts.sv
tests/tb_raizing_obj.sv

// ==== src/obj_line_buf.sv ====
// ==========================================================
// obj_line_buf
// double line buffer. One half takes render writes while
// the other is played out and cleared behind the read
// ==========================================================
module obj_line_buf
    import video_pkg::*;
(
    input  logic   CLK96,
    input  logic   RESET96,
    input  logic   hb_i,
    input  logic   pixel_cen_i,
    input  line_t  h_i,
    input  logic   wr_en_i,
    input  line_t  wr_addr_i,
    input  pixel_t wr_pixel_i,
    output pixel_t obj_pixel_o
);

pixel_t mem [2][POS_WRAP];
logic   hb_q;
logic   sel;        // half taking render writes
logic   clr_on;     // sweep after reset
line_t  clr_cnt;

always_ff @(posedge CLK96 or posedge RESET96) begin
    if (RESET96) begin
        hb_q        <= 1'b0;
        sel         <= 1'b0;
        clr_on      <= 1'b1;
        clr_cnt     <= '0;
        obj_pixel_o <= '0;
    end else begin
        hb_q <= hb_i;
        if (hb_q && !hb_i) sel <= ~sel;   // swap halves at end of hblank
        if (clr_on) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == line_t'(POS_WRAP - 1)) clr_on <= 1'b0;
        end
        if (pixel_cen_i) obj_pixel_o <= clr_on ? '0 : mem[~sel][h_i];
    end
end

// the sweep needs 512 cycles, the first sprite write comes after a full scan
always_ff @(posedge CLK96) begin
    for (int b = 0; b < 2; b++) begin
        if (clr_on) begin
            mem[b][clr_cnt] <= '0;
        end else if (sel == b[0]) begin
            if (wr_en_i) mem[b][wr_addr_i] <= wr_pixel_i;
        end else if (pixel_cen_i) begin
            mem[b][h_i] <= '0;            // blank for the next line
        end
    end
end

endmodule

// ==== src/obj_line_scan.sv ====
// ==========================================================
// obj_line_scan
// per-line sequencer of the sprite engine. On the end of
// hblank it walks all sprite slots, runs the vertical hit
// test, pushes hits into the priority queue and then hands
// the attribute RAM ports to the drawer
// ==========================================================
module obj_line_scan
    import obj_pkg::*;
    import video_pkg::*;
(
    input  logic      CLK96,
    input  logic      RESET96,
    input  logic      hb_i,
    input  line_t     vrender_i,
    input  pos_t      scroll_y_i,
    input  ram_word_t ram_dout_a_i,
    input  ram_word_t ram_dout_b_i,
    input  ram_addr_t draw_addr_a_i,
    input  ram_addr_t draw_addr_b_i,
    input  logic      draw_done_i,
    output ram_addr_t ram_addr_a_o,
    output ram_addr_t ram_addr_b_o,
    output logic      push_o,
    output pri_t      push_pri_o,
    output spr_idx_t  push_idx_o,
    output logic      clear_o,
    output logic      draw_start_o
);

scan_state_t state;
logic        hb_q;
spr_idx_t    spr;       // slot under test
line_t       vline;     // line being rendered
logic        any_hit;
pos_t        dy;
logic [7:0]  height;
logic        hit;

// distance from the sprite top, wraps at 512
assign dy     = vline - ram_dout_b_i[W3_YPOS_HI:W3_YPOS_LO] - scroll_y_i;
assign height = {({1'b0, ram_dout_b_i[W3_YSIZE_HI:W3_YSIZE_LO]} + 5'd1), 3'b000};
assign hit    = ram_dout_a_i[W0_ACTIVE] && (dy < {1'b0, height});

assign push_o     = (state == SCAN_TEST) && hit;
assign push_pri_o = ram_dout_a_i[W0_PRI_HI:W0_PRI_LO];
assign push_idx_o = spr;

// word 0 on port a, word 3 on port b while scanning
assign ram_addr_a_o = (state == DRAW) ? draw_addr_a_i : attr_addr(spr, 2'd0);
assign ram_addr_b_o = (state == DRAW) ? draw_addr_b_i : attr_addr(spr, 2'd3);

always_ff @(posedge CLK96 or posedge RESET96) begin
    if (RESET96) begin
        state        <= IDLE;
        hb_q         <= 1'b0;
        spr          <= '0;
        vline        <= '0;
        any_hit      <= 1'b0;
        clear_o      <= 1'b0;
        draw_start_o <= 1'b0;
    end else begin
        hb_q         <= hb_i;
        clear_o      <= 1'b0;
        draw_start_o <= 1'b0;
        case (state)
            IDLE: begin
                if (hb_q && !hb_i) begin  // end of hblank
                    vline   <= vrender_i;
                    spr     <= '0;
                    any_hit <= 1'b0;
                    clear_o <= 1'b1;
                    state   <= SCAN_ADDR;
                end
            end
            SCAN_ADDR: state <= SCAN_WAIT;
            SCAN_WAIT: state <= SCAN_TEST;    // RAM data valid from here
            SCAN_TEST: begin
                any_hit <= any_hit | hit;
                if (spr == spr_idx_t'(NUM_SPRITES - 1)) begin
                    if (any_hit || hit) begin
                        draw_start_o <= 1'b1;
                        state        <= DRAW;
                    end else begin
                        state <= IDLE;        // nothing on this line
                    end
                end else begin
                    spr   <= spr + 1'b1;
                    state <= SCAN_ADDR;
                end
            end
            DRAW: begin
                if (draw_done_i) state <= IDLE;
            end
            default: state <= IDLE;
        endcase
    end
end

endmodule

// ==== src/obj_pkg.sv ====
// ==========================================================
// obj_pkg
// sprite attribute RAM layout, sprite counts, priority
// bucket sizes and the FSM encodings of the sprite engine
// ==========================================================
package obj_pkg;

    localparam int NUM_SPRITES      = 256;
    localparam int NUM_PRI          = 16;
    localparam int PRI_DEPTH        = 256;  // entries per priority bucket
    localparam int WORDS_PER_SPRITE = 4;

    typedef logic [7:0]  spr_idx_t;
    typedef logic [3:0]  pri_t;
    typedef logic [9:0]  ram_addr_t;
    typedef logic [15:0] ram_word_t;
    typedef logic [3:0]  size_t;      // tile count minus one
    typedef logic [8:0]  pos_t;
    typedef logic [5:0]  pal_t;
    typedef logic [14:0] tile_num_t;

    // word 0, flags, priority and palette
    localparam int W0_ACTIVE = 15;
    localparam int W0_YFLIP  = 13;
    localparam int W0_XFLIP  = 12;
    localparam int W0_PRI_HI = 11;
    localparam int W0_PRI_LO = 8;
    localparam int W0_PAL_HI = 7;
    localparam int W0_PAL_LO = 2;
    // word 1, tile number
    localparam int W1_TILE_HI = 14;
    localparam int W1_TILE_LO = 0;
    // words 2 and 3 share one layout for x and y
    localparam int W2_XPOS_HI  = 15;
    localparam int W2_XPOS_LO  = 7;
    localparam int W2_XSIZE_HI = 3;
    localparam int W2_XSIZE_LO = 0;
    localparam int W3_YPOS_HI  = 15;
    localparam int W3_YPOS_LO  = 7;
    localparam int W3_YSIZE_HI = 3;
    localparam int W3_YSIZE_LO = 0;

    typedef enum logic [2:0] {
        IDLE, SCAN_ADDR, SCAN_WAIT, SCAN_TEST, DRAW
    } scan_state_t;

    typedef enum logic [2:0] {
        POP, ATTR_A, ATTR_B, ATTR_WAIT, SETUP, FETCH, PLOT, DONE
    } draw_state_t;

    // word address of one attribute word of a sprite
    function automatic ram_addr_t attr_addr(input spr_idx_t idx, input logic [1:0] word);
        return ram_addr_t'(idx) * ram_addr_t'(WORDS_PER_SPRITE) + ram_addr_t'(word);
    endfunction

endpackage

// ==== src/obj_pri_queue.sv ====
// ==========================================================
// obj_pri_queue
// sprite index buckets, one per priority level. Pops come
// out lowest level first, in push order within a level
// ==========================================================
module obj_pri_queue
    import obj_pkg::*;
(
    input  logic     CLK96,
    input  logic     RESET96,
    input  logic     clear_i,
    input  logic     push_i,
    input  pri_t     push_pri_i,
    input  spr_idx_t push_idx_i,
    input  logic     pop_i,
    output spr_idx_t pop_idx_o,
    output pri_t     pop_pri_o,
    output logic     empty_o
);

spr_idx_t           mem [NUM_PRI*PRI_DEPTH];
spr_idx_t           wr_cnt [NUM_PRI];
spr_idx_t           rd_cnt [NUM_PRI];
logic [NUM_PRI-1:0] mask;     // levels still holding entries
pri_t               lvl;

function automatic pri_t lowest(input logic [NUM_PRI-1:0] m);
    pri_t r;
    r = '0;
    for (int i = NUM_PRI - 1; i >= 0; i--) begin
        if (m[i]) r = pri_t'(i);
    end
    return r;
endfunction

assign lvl = lowest(mask);

always_ff @(posedge CLK96 or posedge RESET96) begin
    if (RESET96) begin
        mask    <= '0;
        empty_o <= 1'b1;
        for (int i = 0; i < NUM_PRI; i++) begin
            wr_cnt[i] <= '0;
            rd_cnt[i] <= '0;
        end
    end else if (clear_i) begin
        mask <= '0;
        for (int i = 0; i < NUM_PRI; i++) begin
            wr_cnt[i] <= '0;
            rd_cnt[i] <= '0;
        end
    end else begin
        if (push_i) begin
            wr_cnt[push_pri_i] <= wr_cnt[push_pri_i] + 1'b1;
            mask[push_pri_i]   <= 1'b1;
        end
        if (pop_i) begin
            empty_o <= ~|mask;
            if (mask[lvl]) begin
                rd_cnt[lvl] <= rd_cnt[lvl] + 1'b1;
                // 8-bit counts wrap, so a full bucket of 256 still drains
                if (spr_idx_t'(rd_cnt[lvl] + 1'b1) == wr_cnt[lvl]) mask[lvl] <= 1'b0;
            end
        end
    end
end

always_ff @(posedge CLK96) begin
    if (push_i) mem[{push_pri_i, wr_cnt[push_pri_i]}] <= push_idx_i;
    if (pop_i) begin
        pop_idx_o <= mem[{lvl, rd_cnt[lvl]}];
        pop_pri_o <= lvl;
    end
end

endmodule

// ==== src/obj_tile_draw.sv ====
// ==========================================================
// obj_tile_draw
// sprite drawer. Pops queued sprites, re-reads their
// attributes, fetches one 8-pixel slice per tile column and
// plots the opaque pixels into the line buffer
// ==========================================================
module obj_tile_draw
    import obj_pkg::*;
    import video_pkg::*;
(
    input  logic       CLK96,
    input  logic       RESET96,
    input  logic       draw_start_i,
    input  spr_idx_t   pop_idx_i,
    input  pri_t       pop_pri_i,
    input  logic       empty_i,
    input  ram_word_t  ram_dout_a_i,
    input  ram_word_t  ram_dout_b_i,
    input  line_t      vrender_i,
    input  pos_t       scroll_x_i,
    input  pos_t       scroll_y_i,
    input  logic       gfx_ok_i,
    input  slice_t     gfx_data_i,
    output logic       pop_o,
    output ram_addr_t  draw_addr_a_o,
    output ram_addr_t  draw_addr_b_o,
    output logic       draw_done_o,
    output logic       gfx_cs_o,
    output tile_num_t  tile_num_o,
    output tile_offs_t tile_offs_o,
    output logic       wr_en_o,
    output line_t      wr_addr_o,
    output pixel_t     wr_pixel_o
);

draw_state_t state;
logic        xflip;
logic        yflip;
pal_t        pal;
pos_t        sx;          // scrolled x of the left edge
size_t       xsize;
size_t       ysize;
size_t       col;         // tile column being drawn
pos_t        dy;          // line within sprite, from the top
logic [6:0]  line_in;
tile_offs_t  row_base;
slice_t      slice;
logic [2:0]  cnt;
logic [2:0]  tx;
pos_t        colx;
line_t       pix_x;
code_t       nib;

assign pop_o    = (state == POP);
assign gfx_cs_o = (state == FETCH);  // held until the ack, low the cycle after

// words 0/1 in ATTR_A, words 2/3 in ATTR_B
assign draw_addr_a_o = attr_addr(pop_idx_i, (state == ATTR_A) ? 2'd0 : 2'd2);
assign draw_addr_b_o = attr_addr(pop_idx_i, (state == ATTR_A) ? 2'd1 : 2'd3);

// yflip counts from the bottom edge
assign line_in     = yflip ? {ysize, 3'b111} - dy[6:0] : dy[6:0];
assign tile_offs_o = row_base + {col, 5'b00000};

// with xflip the column order and the pixel order are both mirrored
assign colx  = sx + {(xflip ? xsize - col : col), 3'b000};
assign tx    = xflip ? ~cnt : cnt;
assign nib   = slice[{tx, 2'b00} +: 4];
assign pix_x = colx + cnt;               // wraps at 512

always_ff @(posedge CLK96 or posedge RESET96) begin
    if (RESET96) begin
        state       <= DONE;
        draw_done_o <= 1'b0;
        wr_en_o     <= 1'b0;
        col         <= '0;
        cnt         <= '0;
    end else begin
        draw_done_o <= 1'b0;
        wr_en_o     <= (state == PLOT) && (nib != '0) && (pix_x < LINE_W);
        case (state)
            DONE: begin
                if (draw_start_i) state <= POP;
            end
            POP: state <= ATTR_A;
            ATTR_A: begin                  // queue answer valid now
                if (empty_i) begin
                    draw_done_o <= 1'b1;
                    state       <= DONE;
                end else begin
                    state <= ATTR_B;
                end
            end
            ATTR_B:    state <= ATTR_WAIT;
            ATTR_WAIT: state <= SETUP;
            SETUP: begin
                col   <= '0;
                state <= FETCH;
            end
            FETCH: begin
                if (gfx_ok_i) begin
                    cnt   <= '0;
                    state <= PLOT;
                end
            end
            PLOT: begin
                cnt <= cnt + 1'b1;
                if (cnt == 3'd7) begin
                    if (col == xsize) begin
                        state <= POP;      // sprite finished
                    end else begin
                        col   <= col + 1'b1;
                        state <= FETCH;
                    end
                end
            end
            default: state <= DONE;
        endcase
    end
end

always_ff @(posedge CLK96) begin
    case (state)
        ATTR_B: begin
            xflip      <= ram_dout_a_i[W0_XFLIP];
            yflip      <= ram_dout_a_i[W0_YFLIP];
            pal        <= ram_dout_a_i[W0_PAL_HI:W0_PAL_LO];
            tile_num_o <= ram_dout_b_i[W1_TILE_HI:W1_TILE_LO];
        end
        ATTR_WAIT: begin
            sx    <= ram_dout_a_i[W2_XPOS_HI:W2_XPOS_LO] + scroll_x_i;
            xsize <= ram_dout_a_i[W2_XSIZE_HI:W2_XSIZE_LO];
            ysize <= ram_dout_b_i[W3_YSIZE_HI:W3_YSIZE_LO];
            dy    <= vrender_i - ram_dout_b_i[W3_YPOS_HI:W3_YPOS_LO] - scroll_y_i;
        end
        SETUP: begin
            // tile row times sprite width in tiles, 32 words per tile
            row_base <= line_in[6:3] * ({1'b0, xsize} + 5'd1) * 16'd32
                        + {line_in[2:0], 2'b00};
        end
        FETCH: begin
            if (gfx_ok_i) slice <= gfx_data_i;
        end
        default: ;
    endcase
    wr_addr_o  <= pix_x;
    wr_pixel_o <= {pop_pri_i, 1'b0, pal, nib};
end

endmodule

// ==== src/raizing_obj.sv ====
// ==========================================================
// raizing_obj
// per-scanline sprite engine top. Scanner, priority queue,
// tile drawer and line buffer wired together
// ==========================================================
module raizing_obj
    import obj_pkg::*;
    import video_pkg::*;
(
    input  logic       CLK96,
    input  logic       RESET96,
    input  logic       hb_i,
    input  logic       pixel_cen_i,
    input  line_t      h_i,
    input  line_t      vrender_i,
    input  pos_t       scroll_x_i,
    input  pos_t       scroll_y_i,
    output ram_addr_t  ram_addr_a_o,
    output ram_addr_t  ram_addr_b_o,
    input  ram_word_t  ram_dout_a_i,
    input  ram_word_t  ram_dout_b_i,
    output logic       gfx_cs_o,
    input  logic       gfx_ok_i,
    output tile_num_t  tile_num_o,
    output tile_offs_t tile_offs_o,
    input  slice_t     gfx_data_i,
    output pixel_t     obj_pixel_o
);

logic      push;
pri_t      push_pri;
spr_idx_t  push_idx;
logic      clear;
logic      draw_start;
logic      draw_done;
logic      pop;
spr_idx_t  pop_idx;
pri_t      pop_pri;
logic      empty;
ram_addr_t draw_addr_a;
ram_addr_t draw_addr_b;
logic      wr_en;
line_t     wr_addr;
pixel_t    wr_pixel;

obj_line_scan i_scan (
    .CLK96         (CLK96),
    .RESET96       (RESET96),
    .hb_i          (hb_i),
    .vrender_i     (vrender_i),
    .scroll_y_i    (scroll_y_i),
    .ram_dout_a_i  (ram_dout_a_i),
    .ram_dout_b_i  (ram_dout_b_i),
    .draw_addr_a_i (draw_addr_a),
    .draw_addr_b_i (draw_addr_b),
    .draw_done_i   (draw_done),
    .ram_addr_a_o  (ram_addr_a_o),
    .ram_addr_b_o  (ram_addr_b_o),
    .push_o        (push),
    .push_pri_o    (push_pri),
    .push_idx_o    (push_idx),
    .clear_o       (clear),
    .draw_start_o  (draw_start)
);

obj_pri_queue i_queue (
    .CLK96      (CLK96),
    .RESET96    (RESET96),
    .clear_i    (clear),
    .push_i     (push),
    .push_pri_i (push_pri),
    .push_idx_i (push_idx),
    .pop_i      (pop),
    .pop_idx_o  (pop_idx),
    .pop_pri_o  (pop_pri),
    .empty_o    (empty)
);

obj_tile_draw i_draw (
    .CLK96         (CLK96),
    .RESET96       (RESET96),
    .draw_start_i  (draw_start),
    .pop_idx_i     (pop_idx),
    .pop_pri_i     (pop_pri),
    .empty_i       (empty),
    .ram_dout_a_i  (ram_dout_a_i),
    .ram_dout_b_i  (ram_dout_b_i),
    .vrender_i     (vrender_i),
    .scroll_x_i    (scroll_x_i),
    .scroll_y_i    (scroll_y_i),
    .gfx_ok_i      (gfx_ok_i),
    .gfx_data_i    (gfx_data_i),
    .pop_o         (pop),
    .draw_addr_a_o (draw_addr_a),
    .draw_addr_b_o (draw_addr_b),
    .draw_done_o   (draw_done),
    .gfx_cs_o      (gfx_cs_o),
    .tile_num_o    (tile_num_o),
    .tile_offs_o   (tile_offs_o),
    .wr_en_o       (wr_en),
    .wr_addr_o     (wr_addr),
    .wr_pixel_o    (wr_pixel)
);

obj_line_buf i_line_buf (
    .CLK96       (CLK96),
    .RESET96     (RESET96),
    .hb_i        (hb_i),
    .pixel_cen_i (pixel_cen_i),
    .h_i         (h_i),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_pixel_i  (wr_pixel),
    .obj_pixel_o (obj_pixel_o)
);

endmodule

// ==== src/video_pkg.sv ====
// ==========================================================
// video_pkg
// line and pixel geometry, output pixel format and the
// graphics slice widths of the sprite engine
// ==========================================================
package video_pkg;

    localparam int LINE_W   = 320;  // visible pixels per line
    localparam int POS_WRAP = 512;  // positions and line buffer wrap here

    typedef logic [8:0]  line_t;     // line or column number
    typedef logic [3:0]  code_t;     // colour code, 0 is transparent

    // priority 14:11, bit 10 zero, palette 9:4, code 3:0
    typedef logic [14:0] pixel_t;

    // eight 4-bit pixels, leftmost pixel in the low nibble
    typedef logic [31:0] slice_t;
    typedef logic [15:0] tile_offs_t;

endpackage

// ==== tests/raizing_obj_asserts.sv ====
// ==========================================================
// raizing_obj_asserts
// protocol checks bound into the sprite engine top. Covers
// the reset state and the hold and release of a graphics
// request around its ack
// ==========================================================
module raizing_obj_asserts
    import obj_pkg::*;
    import video_pkg::*;
(
    input logic       CLK96,
    input logic       RESET96,
    input logic       gfx_cs_o,
    input logic       gfx_ok_i,
    input tile_num_t  tile_num_o,
    input tile_offs_t tile_offs_o,
    input pixel_t     obj_pixel_o
);

timeunit 1ns;
timeprecision 100ps;

int fail_cnt = 0;   // read by the testbench at the end

// no request and a blank pixel while in reset and just after
reset_state: assert property (@(posedge CLK96) RESET96 |=> !gfx_cs_o && obj_pixel_o == '0)
    else begin
        fail_cnt++;
        $error("gfx request or pixel output not idle after reset");
    end

// request and address held until the ack arrives
req_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_o && !gfx_ok_i |=> gfx_cs_o && $stable(tile_num_o) && $stable(tile_offs_o))
    else begin
        fail_cnt++;
        $error("gfx request dropped or address changed before the ack");
    end

ack_release: assert property (@(posedge CLK96) disable iff (RESET96) gfx_ok_i |=> !gfx_cs_o)
    else begin
        fail_cnt++;
        $error("gfx request still high in the cycle after the ack");
    end

endmodule

bind raizing_obj raizing_obj_asserts i_asserts (.*);

// ==== tests/tb_raizing_obj.sv ====
// ==========================================================
// tb_raizing_obj
// testbench for the sprite engine. Models the attribute RAM
// and the graphics ROM, plays whole scanlines and checks
// every output pixel against a reference line model
// ==========================================================
module tb_raizing_obj;

timeunit 1ns;
timeprecision 100ps;

localparam int SCROLL_X       = 16;
localparam int SCROLL_Y       = 8;
localparam int LINE_PIX       = 384;  // hblank from column 320
localparam int VISIBLE        = 320;
localparam int TIMEOUT_CYCLES = 12 * LINE_PIX * 4 + 2000;

logic        CLK96;
logic        RESET96;
logic        hb_i;
logic        pixel_cen_i;
logic [8:0]  h_i;
logic [8:0]  vrender_i;
logic [8:0]  scroll_x_i;
logic [8:0]  scroll_y_i;
logic [9:0]  ram_addr_a_o;
logic [9:0]  ram_addr_b_o;
logic [15:0] ram_dout_a_i;
logic [15:0] ram_dout_b_i;
logic        gfx_cs_o;
logic        gfx_ok_i;
logic [14:0] tile_num_o;
logic [15:0] tile_offs_o;
logic [31:0] gfx_data_i;
logic [14:0] obj_pixel_o;

logic [15:0] attr_ram [1024];
logic [14:0] render_exp [VISIBLE];  // line going into the render half
logic [14:0] disp_exp [VISIBLE];    // line on display
string       render_name = "reset";
string       disp_name   = "reset";
string       exp_name    = "reset";
logic [14:0] exp_q       = '0;
logic [8:0]  exp_col     = '0;
int          pix_errors  = 0;
int          proto_errors;
int          cycle_cnt   = 0;
int unsigned rand_state  = 7812;
int          ack_wait    = 0;

raizing_obj i_dut (.*);

initial begin
    CLK96 = 1'b0;
    forever #5 CLK96 = ~CLK96;
end

function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// graphics ROM, nibbles follow tile and offset
function automatic logic [31:0] rom_slice(input logic [14:0] tile, input logic [15:0] offs);
    logic [31:0] r;
    int          k;
    r = '0;
    k = int'(offs) >> 2;
    for (int i = 0; i < 8; i++) begin
        if ((k + i) % 4 != 3) r[i*4 +: 4] = 4'(int'(tile) + k * 5 + i * 3);  // else transparent
    end
    return r;
endfunction

// expected render of one line, later writes win
function automatic void build_line(input int vline);
    logic [15:0] w0;
    logic [15:0] w1;
    logic [15:0] w2;
    logic [15:0] w3;
    logic [31:0] sl;
    logic [3:0]  code;
    int          dy;
    int          hgt;
    int          xt;
    int          line_in;
    int          s;
    int          x;
    int          offs;
    for (int c = 0; c < VISIBLE; c++) render_exp[c] = '0;
    for (int p = 0; p < 16; p++) begin
        for (int i = 0; i < 256; i++) begin
            w0  = attr_ram[i*4];
            w1  = attr_ram[i*4 + 1];
            w2  = attr_ram[i*4 + 2];
            w3  = attr_ram[i*4 + 3];
            dy  = (vline - int'(w3[15:7]) - SCROLL_Y) & 511;
            hgt = (int'(w3[3:0]) + 1) * 8;
            xt  = int'(w2[3:0]) + 1;                     // tiles across
            if (w0[15] && int'(w0[11:8]) == p && dy < hgt) begin
                line_in = w0[13] ? hgt - 1 - dy : dy;
                for (int px = 0; px < xt * 8; px++) begin
                    // source pixel, mirrored with xflip
                    s    = w0[12] ? xt * 8 - 1 - px : px;
                    offs = (line_in / 8) * xt * 32 + (line_in % 8) * 4 + (s / 8) * 32;
                    sl   = rom_slice(w1[14:0], 16'(offs));
                    code = sl[(s % 8) * 4 +: 4];
                    x    = (int'(w2[15:7]) + SCROLL_X + px) & 511;
                    if (code != 4'd0 && x < VISIBLE) begin
                        render_exp[x] = {4'(p), 1'b0, w0[7:2], code};
                    end
                end
            end
        end
    end
endfunction

task automatic fill_ram();
    for (int a = 0; a < 1024; a++) begin
        attr_ram[a] = 16'(a * 2531 + 81);
        if (a % 4 == 0) attr_ram[a][15] = 1'b0;  // every slot inactive
    end
endtask

task automatic write_sprite(input int idx, input bit active, input bit xflip, input bit yflip,
                            input int pri, input int pal, input int tile,
                            input int xpos, input int xsize, input int ypos, input int ysize);
    attr_ram[idx*4]     = {active, 1'b0, yflip, xflip, 4'(pri), 6'(pal), 2'b00};
    attr_ram[idx*4 + 1] = {1'b0, 15'(tile)};
    attr_ram[idx*4 + 2] = {9'(xpos), 3'b000, 4'(xsize)};
    attr_ram[idx*4 + 3] = {9'(ypos), 3'b000, 4'(ysize)};
endtask

// one scanline, pixel enable one cycle after each column change
task automatic run_line(input int vline, input string name);
    disp_exp    = render_exp;
    disp_name   = render_name;
    build_line(vline);
    render_name = name;
    for (int h = 0; h < LINE_PIX; h++) begin
        @(posedge CLK96);
        h_i  <= 9'(h);
        hb_i <= (h >= VISIBLE);
        if (h == 0) vrender_i <= 9'(vline);
        @(posedge CLK96);
        pixel_cen_i <= 1'b1;
        @(posedge CLK96);
        pixel_cen_i <= 1'b0;
        @(posedge CLK96);
    end
endtask

// attribute RAM, one cycle read latency on both ports
always @(posedge CLK96) begin
    ram_dout_a_i <= attr_ram[ram_addr_a_o];
    ram_dout_b_i <= attr_ram[ram_addr_b_o];
end

// graphics ROM acks after 1 to 6 cycles
always @(posedge CLK96) begin
    gfx_ok_i <= 1'b0;
    if (ack_wait > 0) begin
        ack_wait <= ack_wait - 1;
        if (ack_wait == 1) begin
            gfx_ok_i   <= 1'b1;
            gfx_data_i <= rom_slice(tile_num_o, tile_offs_o);
        end
    end else if (gfx_cs_o && !gfx_ok_i) begin
        rand_state = lcg_next(rand_state);
        ack_wait <= 1 + int'((rand_state >> 16) % 6);
    end
end

always @(posedge CLK96) begin
    if (pixel_cen_i) begin
        exp_q    <= (h_i < VISIBLE) ? disp_exp[h_i] : '0;
        exp_col  <= h_i;
        exp_name <= disp_name;
    end
end

check_pixel: assert property (@(posedge CLK96) disable iff (RESET96)
        pixel_cen_i |=> obj_pixel_o === exp_q)
    else begin
        pix_errors++;
        $display("Fail %s column %0d expected %h actual %h",
                 exp_name, exp_col, exp_q, obj_pixel_o);
    end

initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
        @(posedge CLK96);
        cycle_cnt++;
    end
    $display("timeout, the scanlines did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
end

initial begin
    RESET96      = 1'b1;
    hb_i         = 1'b1;
    pixel_cen_i  = 1'b0;
    h_i          = 9'(VISIBLE);
    vrender_i    = '0;
    scroll_x_i   = 9'(SCROLL_X);
    scroll_y_i   = 9'(SCROLL_Y);
    ram_dout_a_i = '0;
    ram_dout_b_i = '0;
    gfx_ok_i     = 1'b0;
    gfx_data_i   = '0;
    for (int c = 0; c < VISIBLE; c++) render_exp[c] = '0;
    fill_ram();
    repeat (3) @(posedge CLK96);
    RESET96 <= 1'b0;
    repeat (2) @(posedge CLK96);

    // two tiles wide, two tiles tall, rows from both tile rows
    write_sprite(5, 1, 0, 0, 3, 'h15, 'h123, 40, 1, 20, 1);
    run_line(30, "single_sprite");
    run_line(41, "single_sprite");

    fill_ram();
    write_sprite(9, 1, 1, 1, 2, 'h2a, 'h456, 100, 2, 60, 1);
    run_line(70, "flip_xy");
    run_line(83, "flip_xy");      // last sprite line
    run_line(84, "flip_xy");      // below the sprite

    fill_ram();
    write_sprite(20, 1, 0, 0, 5, 'h11, 'h200, 150, 1, 140, 1);
    write_sprite(21, 1, 0, 0, 4, 'h22, 'h300, 158, 1, 140, 1);
    write_sprite(30, 1, 0, 0, 6, 'h33, 'h410, 220, 1, 140, 1);
    write_sprite(31, 1, 0, 0, 6, 'h0c, 'h520, 226, 1, 140, 1);
    run_line(150, "overlap");

    fill_ram();
    write_sprite(40, 1, 0, 0, 7, 'h05, 'h600, 296, 1, 190, 0);  // crosses column 320
    write_sprite(41, 0, 0, 0, 7, 'h06, 'h610, 100, 1, 190, 0);
    write_sprite(42, 1, 0, 0, 7, 'h07, 'h620, 490, 1, 190, 0);  // wraps past 511
    run_line(200, "clip_inactive");

    fill_ram();
    run_line(200, "cleared");
    run_line(200, "cleared");

    repeat (4) @(posedge CLK96);
    proto_errors = i_dut.i_asserts.fail_cnt;
    $display("errors: pixel %0d, protocol %0d", pix_errors, proto_errors);
    if (pix_errors == 0 && proto_errors == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule
